// File: common/mips_dbg_pkg.sv
package mips_dbg_pkg;

	////////////////////////////////////////
	// widths
	////////////////////////////////////////

	// data and instruction word
	typedef logic [31:0] word_t;
	// one uart byte
	typedef logic [7:0] byte_t;
	// low three bits of rs, rt, rd
	typedef logic [2:0] reg_idx_t;
	// instruction memory address, 32 words
	typedef logic [4:0] imem_addr_t;
	// dump word select, 0 to 9
	typedef logic [3:0] dump_sel_t;
	// opcode and funct fields
	typedef logic [5:0] opcode_t;
	typedef logic [5:0] funct_t;

	////////////////////////////////////////
	// isa encodings
	////////////////////////////////////////

	localparam opcode_t OP_RTYPE = 6'd0;
	localparam opcode_t OP_BEQ   = 6'd4;
	localparam opcode_t OP_ADDI  = 6'd8;
	localparam opcode_t OP_HALT  = 6'd63;

	localparam funct_t FN_ADD = 6'd32;
	localparam funct_t FN_SUB = 6'd34;
	localparam funct_t FN_AND = 6'd36;
	localparam funct_t FN_OR  = 6'd37;

	// host command bytes, ascii L and R
	localparam byte_t CMD_LOAD = 8'h4c;
	localparam byte_t CMD_RUN  = 8'h52;

	// dump layout: r0..r7, then pc, then cycle count
	localparam int        DUMP_WORDS = 10;
	localparam dump_sel_t SEL_PC     = 4'd8;
	localparam dump_sel_t SEL_CYCLES = 4'd9;

	// debug unit fsm
	typedef enum logic [2:0] {
		IDLE,
		LOAD_COUNT,
		LOAD_BYTES,
		RUNNING,
		DUMP_SEND,
		DUMP_WAIT
	} dbg_state_t;

endpackage

// File: common/uart_if.sv
`timescale 1ns/1ns

// byte level link, uart halves <-> debug unit
interface uart_if import mips_dbg_pkg::*; ();

	// receive side, done is a one cycle pulse
	byte_t rx_data;
	logic  rx_done;

	// transmit side, start is a one cycle pulse
	byte_t tx_data;
	logic  tx_start;
	// pulses at end of stop bit
	logic  tx_done;

	modport rx (
		output rx_data,
		output rx_done
	);

	modport tx (
		input  tx_data,
		input  tx_start,
		output tx_done
	);

	modport dbg (
		input  rx_data,
		input  rx_done,
		input  tx_done,
		output tx_data,
		output tx_start
	);

endinterface

// File: common/core_dbg_if.sv
`timescale 1ns/1ns

// debug unit <-> core: program load, run control, dump readout
interface core_dbg_if import mips_dbg_pkg::*; ();

	// run control
	logic run;
	logic start;
	// level, high while core is stopped
	logic halted;

	// imem write port, one word per wr_en pulse
	logic       wr_en;
	imem_addr_t wr_addr;
	word_t      wr_data;

	// dump readout, combinational in the core
	dump_sel_t rd_sel;
	word_t     rd_word;

	modport dbg (
		output run,
		output start,
		output wr_en,
		output wr_addr,
		output wr_data,
		output rd_sel,
		input  halted,
		input  rd_word
	);

	modport core (
		input  run,
		input  start,
		input  wr_en,
		input  wr_addr,
		input  wr_data,
		input  rd_sel,
		output halted,
		output rd_word
	);

endinterface

// File: uart/uart_rx.sv
`timescale 1ns/1ns

module uart_rx import mips_dbg_pkg::*; #(
	parameter int CLKS_PER_BIT = 10416
) (
	input  logic clk,
	input  logic rst_n,
	input  logic rx_line,
	uart_if.rx   u
);

	localparam int CNT_W = $clog2(CLKS_PER_BIT);

	logic             rx_meta;
	logic             rx_sync;
	logic             rx_prev;
	logic             busy;
	logic [CNT_W-1:0] clk_cnt;
	// 0 start, 1..8 data, 9 stop
	logic [3:0]       bit_idx;
	logic             sample_tick;
	byte_t            shift_q;
	logic             done_q;

	////////////////////////////////////////
	// input sync and edge detect
	////////////////////////////////////////

	// idle line is high
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
			rx_prev <= 1'b1;
		end else begin
			rx_meta <= rx_line;
			rx_sync <= rx_meta;
			rx_prev <= rx_sync;
		end
	end

	// counter hit zero -> middle of a bit
	assign sample_tick = busy && (clk_cnt == '0);

	////////////////////////////////////////
	// bit timing
	////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy    <= 1'b0;
			clk_cnt <= '0;
			bit_idx <= '0;
			done_q  <= 1'b0;
		end else begin
			done_q <= 1'b0;
			if (!busy) begin
				// falling edge, first sample half a bit later
				if (rx_prev && !rx_sync) begin
					busy    <= 1'b1;
					clk_cnt <= CNT_W'(CLKS_PER_BIT / 2 - 1);
					bit_idx <= '0;
				end
			end else if (clk_cnt != '0) begin
				clk_cnt <= clk_cnt - 1'b1;
			end else begin
				clk_cnt <= CNT_W'(CLKS_PER_BIT - 1);
				bit_idx <= bit_idx + 1'b1;
				if (bit_idx == 4'd0) begin
					// start bit gone high again, glitch
					if (rx_sync)
						busy <= 1'b0;
				end else if (bit_idx == 4'd9) begin
					busy <= 1'b0;
					// bad stop bit drops the frame
					done_q <= rx_sync;
				end
			end
		end
	end

	// data bits, lsb first
	always_ff @(posedge clk) begin
		if (sample_tick && (bit_idx >= 4'd1) && (bit_idx <= 4'd8))
			shift_q <= {rx_sync, shift_q[7:1]};
	end

	assign u.rx_data = shift_q;
	assign u.rx_done = done_q;

endmodule

// File: uart/uart_tx.sv
`timescale 1ns/1ns

module uart_tx #(
	parameter int CLKS_PER_BIT = 10416
) (
	input  logic clk,
	input  logic rst_n,
	output logic tx_line,
	uart_if.tx   u
);

	localparam int CNT_W = $clog2(CLKS_PER_BIT);

	logic             busy;
	logic [CNT_W-1:0] clk_cnt;
	logic [3:0]       bit_idx;
	// stop, data, start; bit 0 is on the line
	logic [9:0]       frame_q;
	logic             done_q;

	////////////////////////////////////////
	// frame shifter
	////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy    <= 1'b0;
			clk_cnt <= '0;
			bit_idx <= '0;
			// all ones keeps the line idle high
			frame_q <= '1;
			done_q  <= 1'b0;
		end else begin
			done_q <= 1'b0;
			if (!busy) begin
				// start strobe ignored while busy
				if (u.tx_start) begin
					busy    <= 1'b1;
					frame_q <= {1'b1, u.tx_data, 1'b0};
					clk_cnt <= CNT_W'(CLKS_PER_BIT - 1);
					bit_idx <= '0;
				end
			end else if (clk_cnt != '0) begin
				clk_cnt <= clk_cnt - 1'b1;
			end else begin
				// next bit, fill with idle level
				frame_q <= {1'b1, frame_q[9:1]};
				clk_cnt <= CNT_W'(CLKS_PER_BIT - 1);
				if (bit_idx == 4'd9) begin
					// end of stop bit
					busy   <= 1'b0;
					done_q <= 1'b1;
				end else begin
					bit_idx <= bit_idx + 1'b1;
				end
			end
		end
	end

	assign tx_line   = frame_q[0];
	assign u.tx_done = done_q;

endmodule

// File: mips/mips_core.sv
`timescale 1ns/1ns

module mips_core import mips_dbg_pkg::*; #(
	parameter int IMEM_DEPTH = 32
) (
	input  logic     clk,
	input  logic     rst_n,
	core_dbg_if.core d
);

	// program storage
	word_t      imem [IMEM_DEPTH];
	// r1..r7, r0 reads as zero
	word_t      regs [1:7];

	imem_addr_t pc;
	word_t      cycles;
	logic       halted_q;
	logic       exec;

	// decode fields
	word_t      instr;
	opcode_t    opcode;
	funct_t     funct;
	reg_idx_t   rs;
	reg_idx_t   rt;
	reg_idx_t   rd;
	word_t      imm_sext;
	word_t      rs_val;
	word_t      rt_val;

	// execute results
	logic       rf_we;
	reg_idx_t   rf_waddr;
	word_t      rf_wdata;
	logic       do_halt;
	imem_addr_t pc_next;
	word_t      dump_word;

	function automatic word_t rf_read(input reg_idx_t idx);
		word_t val;
		val = '0;
		if (idx != '0)
			val = regs[idx];
		return val;
	endfunction

	////////////////////////////////////////
	// fetch and decode
	////////////////////////////////////////

	assign exec     = d.run && !halted_q;
	assign instr    = imem[pc];
	assign opcode   = instr[31:26];
	assign funct    = instr[5:0];
	// only low three bits of each register field
	assign rs       = instr[23:21];
	assign rt       = instr[18:16];
	assign rd       = instr[13:11];
	assign imm_sext = {{16{instr[15]}}, instr[15:0]};
	assign rs_val   = rf_read(rs);
	assign rt_val   = rf_read(rt);

	// alu, branch and halt
	always_comb begin
		rf_we    = 1'b0;
		rf_waddr = rd;
		rf_wdata = '0;
		do_halt  = 1'b0;
		pc_next  = pc + 1'b1;
		case (opcode)
			OP_RTYPE: begin
				rf_we = 1'b1;
				case (funct)
					FN_ADD: rf_wdata = rs_val + rt_val;
					FN_SUB: rf_wdata = rs_val - rt_val;
					FN_AND: rf_wdata = rs_val & rt_val;
					FN_OR:  rf_wdata = rs_val | rt_val;
					// unknown funct, no write
					default: rf_we = 1'b0;
				endcase
			end
			OP_ADDI: begin
				rf_we    = 1'b1;
				rf_waddr = rt;
				rf_wdata = rs_val + imm_sext;
			end
			OP_BEQ: begin
				// target pc + 1 + offset, wraps in imem
				if (rs_val == rt_val)
					pc_next = imem_addr_t'(word_t'(pc) + 32'd1 + imm_sext);
			end
			OP_HALT: do_halt = 1'b1;
			default: ;
		endcase
	end

	////////////////////////////////////////
	// state
	////////////////////////////////////////

	// loader write port
	always_ff @(posedge clk) begin
		if (d.wr_en)
			imem[d.wr_addr] <= d.wr_data;
	end

	// halted out of reset, start clears it
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc       <= '0;
			cycles   <= '0;
			halted_q <= 1'b1;
		end else if (d.start) begin
			pc       <= '0;
			cycles   <= '0;
			halted_q <= 1'b0;
		end else if (exec) begin
			// halt counts as a cycle, pc stays on it
			cycles <= cycles + 1'b1;
			if (do_halt)
				halted_q <= 1'b1;
			else
				pc <= pc_next;
		end
	end

	// register file, survives between runs
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 1; i < 8; i++)
				regs[i] <= '0;
		end else if (exec && rf_we && (rf_waddr != '0)) begin
			regs[rf_waddr] <= rf_wdata;
		end
	end

	// dump mux
	always_comb begin
		if (d.rd_sel < SEL_PC)
			dump_word = rf_read(reg_idx_t'(d.rd_sel));
		else if (d.rd_sel == SEL_PC)
			dump_word = word_t'(pc);
		else if (d.rd_sel == SEL_CYCLES)
			dump_word = cycles;
		else
			dump_word = '0;
	end

	assign d.halted  = halted_q;
	assign d.rd_word = dump_word;

endmodule

// File: debug/debug_unit.sv
`timescale 1ns/1ns

module debug_unit import mips_dbg_pkg::*; #(
	parameter int IMEM_DEPTH = 32
) (
	input  logic    clk,
	input  logic    rst_n,
	uart_if.dbg     u,
	core_dbg_if.dbg d
);

	// word count 0..IMEM_DEPTH
	localparam int CNT_W = $clog2(IMEM_DEPTH + 1);

	dbg_state_t       state;
	logic [CNT_W-1:0] words_left;
	logic [CNT_W-1:0] count_clip;
	// byte within word, load and dump
	logic [1:0]       byte_idx;
	logic             last_byte;
	imem_addr_t       word_addr;
	word_t            word_buf;
	logic             run_q;
	logic             start_q;
	dump_sel_t        sel_q;
	logic             tx_start_q;
	byte_t            tx_data_q;

	// clip count byte to imem size
	always_comb begin
		if (u.rx_data > byte_t'(IMEM_DEPTH))
			count_clip = CNT_W'(IMEM_DEPTH);
		else
			count_clip = CNT_W'(u.rx_data);
	end

	assign last_byte = (byte_idx == 2'd3);

	// 4th byte completes the word, write in the same cycle
	assign d.wr_en   = (state == LOAD_BYTES) && u.rx_done && last_byte;
	assign d.wr_addr = word_addr;
	assign d.wr_data = {u.rx_data, word_buf[31:8]};

	////////////////////////////////////////
	// command fsm
	////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state      <= IDLE;
			words_left <= '0;
			byte_idx   <= '0;
			word_addr  <= '0;
			run_q      <= 1'b0;
			start_q    <= 1'b0;
			sel_q      <= '0;
			tx_start_q <= 1'b0;
		end else begin
			start_q    <= 1'b0;
			tx_start_q <= 1'b0;
			case (state)
				IDLE: begin
					// only place commands are decoded
					if (u.rx_done) begin
						if (u.rx_data == CMD_LOAD) begin
							state <= LOAD_COUNT;
						end else if (u.rx_data == CMD_RUN) begin
							start_q <= 1'b1;
							state   <= RUNNING;
						end
					end
				end
				LOAD_COUNT: begin
					if (u.rx_done) begin
						byte_idx  <= '0;
						word_addr <= '0;
						words_left <= count_clip;
						if (count_clip == '0)
							state <= IDLE;
						else
							state <= LOAD_BYTES;
					end
				end
				LOAD_BYTES: begin
					if (u.rx_done) begin
						byte_idx <= byte_idx + 1'b1;
						if (last_byte) begin
							word_addr  <= word_addr + 1'b1;
							words_left <= words_left - 1'b1;
							if (words_left == CNT_W'(1))
								state <= IDLE;
						end
					end
				end
				RUNNING: begin
					// run rises the cycle after start
					if (start_q) begin
						run_q <= 1'b1;
					end else if (run_q && d.halted) begin
						run_q    <= 1'b0;
						sel_q    <= '0;
						byte_idx <= '0;
						state    <= DUMP_SEND;
					end
				end
				DUMP_SEND: begin
					tx_start_q <= 1'b1;
					state      <= DUMP_WAIT;
				end
				DUMP_WAIT: begin
					// next byte only after tx_done
					if (u.tx_done) begin
						byte_idx <= byte_idx + 1'b1;
						if (!last_byte) begin
							state <= DUMP_SEND;
						end else if (sel_q == dump_sel_t'(DUMP_WORDS - 1)) begin
							state <= IDLE;
						end else begin
							sel_q <= sel_q + 1'b1;
							state <= DUMP_SEND;
						end
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// load assembly and dump byte pick, lsb first
	always_ff @(posedge clk) begin
		if ((state == LOAD_BYTES) && u.rx_done)
			word_buf <= {u.rx_data, word_buf[31:8]};
		if (state == DUMP_SEND)
			tx_data_q <= d.rd_word[{byte_idx, 3'b000} +: 8];
	end

	assign d.run      = run_q;
	assign d.start    = start_q;
	assign d.rd_sel   = sel_q;
	assign u.tx_start = tx_start_q;
	assign u.tx_data  = tx_data_q;

endmodule

// File: verilog/mips_dbg_top.sv
`timescale 1ns/1ns

module mips_dbg_top #(
	// 100 MHz, 9600 baud
	parameter int CLKS_PER_BIT = 10416,
	parameter int IMEM_DEPTH   = 32
) (
	input  logic clk100mhz,
	input  logic rst_n,
	input  logic rx_line,
	output logic tx_line
);

	// uart <-> debug unit
	uart_if     uart_bus ();
	// debug unit <-> core
	core_dbg_if core_bus ();

	////////////////////////////////////////
	// host link
	////////////////////////////////////////

	uart_rx #(
		.CLKS_PER_BIT(CLKS_PER_BIT)
	) u_uart_rx (
		.clk    (clk100mhz),
		.rst_n  (rst_n),
		.rx_line(rx_line),
		.u      (uart_bus.rx)
	);

	uart_tx #(
		.CLKS_PER_BIT(CLKS_PER_BIT)
	) u_uart_tx (
		.clk    (clk100mhz),
		.rst_n  (rst_n),
		.tx_line(tx_line),
		.u      (uart_bus.tx)
	);

	////////////////////////////////////////
	// debug unit and core
	////////////////////////////////////////

	// core is stopped by run, no clock gating
	debug_unit #(
		.IMEM_DEPTH(IMEM_DEPTH)
	) u_debug_unit (
		.clk  (clk100mhz),
		.rst_n(rst_n),
		.u    (uart_bus.dbg),
		.d    (core_bus.dbg)
	);

	mips_core #(
		.IMEM_DEPTH(IMEM_DEPTH)
	) u_mips_core (
		.clk  (clk100mhz),
		.rst_n(rst_n),
		.d    (core_bus.core)
	);

endmodule

// File: bench/tb_mips_dbg_asserts.sv
`timescale 1ns/1ns

// bound into debug_unit, watches the uart and core links
module tb_mips_dbg_asserts import mips_dbg_pkg::*; (
	input logic       clk,
	input logic       rst_n,
	input dbg_state_t state,
	input logic       tx_start,
	input logic       tx_done,
	input logic       wr_en,
	input logic       run
);

	// set by tx_start, cleared by tx_done
	logic in_flight;
	// assertion failures so far
	int   fail_count = 0;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			in_flight <= 1'b0;
		else if (tx_start)
			in_flight <= 1'b1;
		else if (tx_done)
			in_flight <= 1'b0;
	end

	////////////////////////////////////////
	// link rules
	////////////////////////////////////////

	// one byte at a time on the transmitter
	tx_one_at_a_time: assert property (@(posedge clk) disable iff (!rst_n)
		tx_start |-> !in_flight)
		else begin
			$error("tx_start pulsed while a byte was still in flight");
			fail_count++;
		end

	// imem writes only while loading, never with the core running
	wr_only_in_load: assert property (@(posedge clk) disable iff (!rst_n)
		wr_en |-> !run)
		else begin
			$error("wr_en pulsed while the core was running");
			fail_count++;
		end

	// core parked whenever the fsm is idle
	idle_means_stopped: assert property (@(posedge clk) disable iff (!rst_n)
		(state == IDLE) |-> !run)
		else begin
			$error("run high while the debug fsm is idle");
			fail_count++;
		end

endmodule

bind debug_unit tb_mips_dbg_asserts asserts_i (
	.clk     (clk),
	.rst_n   (rst_n),
	.state   (state),
	.tx_start(tx_start_q),
	.tx_done (u.tx_done),
	.wr_en   (d.wr_en),
	.run     (run_q)
);

// File: bench/tb_mips_dbg.sv
`timescale 1ns/1ns

module tb_mips_dbg import mips_dbg_pkg::*; ();

	localparam int BIT_CLKS = 16;

	logic clk;
	logic rst_n;
	logic rx_line;
	logic tx_line;

	// reference model state, kept across runs like the core
	word_t      model_imem [32];
	word_t      model_regs [8];
	imem_addr_t model_pc;
	word_t      model_cycles;

	// program under test and received dump
	word_t prog [32];
	word_t dump_words [DUMP_WORDS];
	int    rx_count;

	int test_num;
	int test_errors;
	int tests_passed;
	int tests_failed;
	// checker failures already charged to a test
	int assert_seen;

	mips_dbg_top #(
		.CLKS_PER_BIT(BIT_CLKS),
		.IMEM_DEPTH  (32)
	) mips_dbg_top_i (
		.clk100mhz(clk),
		.rst_n    (rst_n),
		.rx_line  (rx_line),
		.tx_line  (tx_line)
	);

	initial clk = 1'b0;
	// 8 ns period
	always #4 clk = ~clk;

	////////////////////////////////////////
	// reporting
	////////////////////////////////////////

	task automatic report_error(input string msg);
		$display("** Error @%0t ns: %s", $time, msg);
		test_errors++;
	endtask

	task automatic abort_on_timeout(input string what);
		$display("timeout at %0t ns: %s", $time, what);
		$display("SOME TESTS FAILED");
		$finish;
	endtask

	task automatic finish_test(input string name);
		int assert_now;
		// failures from the bound checker count against this test
		assert_now = mips_dbg_top_i.u_debug_unit.asserts_i.fail_count;
		if (assert_now != assert_seen) begin
			$display("test %0d %s: %0d link assertions failed", test_num, name,
				assert_now - assert_seen);
			test_errors += assert_now - assert_seen;
			assert_seen = assert_now;
		end
		if (test_errors == 0) begin
			tests_passed++;
			$display("test %0d %s: passed", test_num, name);
		end else begin
			tests_failed++;
			$display("test %0d %s: failed, %0d errors", test_num, name, test_errors);
		end
		test_num++;
		test_errors = 0;
	endtask

	////////////////////////////////////////
	// uart host side
	////////////////////////////////////////

	task automatic wait_cycles(input int n);
		repeat (n) @(negedge clk);
	endtask

	// one bit period, changed on the falling edge
	task automatic drive_bit(input logic v);
		@(negedge clk);
		rx_line = v;
		wait_cycles(BIT_CLKS - 1);
	endtask

	task automatic send_byte(input byte_t b);
		int i;
		drive_bit(1'b0);
		for (i = 0; i < 8; i++)
			drive_bit(b[i]);
		drive_bit(1'b1);
	endtask

	// decode one frame from tx_line, samples near each bit middle
	task automatic recv_byte(output byte_t b, input int limit);
		int n;
		int i;
		n = 0;
		@(negedge clk);
		while (tx_line !== 1'b0) begin
			n++;
			if (n > limit)
				abort_on_timeout("no start bit on tx_line");
			@(negedge clk);
		end
		wait_cycles(BIT_CLKS / 2);
		if (tx_line !== 1'b0)
			report_error("start bit on tx_line did not stay low");
		for (i = 0; i < 8; i++) begin
			wait_cycles(BIT_CLKS);
			b[i] = tx_line;
		end
		wait_cycles(BIT_CLKS);
		if (tx_line !== 1'b1)
			report_error("stop bit on tx_line is low");
	endtask

	// 40 bytes, lsb of each word first
	task automatic receive_dump();
		byte_t b;
		int    w;
		int    k;
		int    limit;
		for (w = 0; w < DUMP_WORDS; w++) begin
			for (k = 0; k < 4; k++) begin
				limit = (rx_count == 0) ? 4000 : 400;
				recv_byte(b, limit);
				dump_words[w][8*k +: 8] = b;
				rx_count++;
			end
		end
	endtask

	// load command while the dump is going out
	task automatic inject_load();
		int n;
		n = 0;
		while (rx_count < 3) begin
			@(negedge clk);
			n++;
			if (n > 20000)
				abort_on_timeout("dump never started, load byte not injected");
		end
		send_byte(CMD_LOAD);
	endtask

	task automatic load_program(input int n);
		int i;
		int k;
		send_byte(CMD_LOAD);
		send_byte(byte_t'(n));
		for (i = 0; i < n; i++) begin
			for (k = 0; k < 4; k++)
				send_byte(prog[i][8*k +: 8]);
			model_imem[i] = prog[i];
		end
	endtask

	task automatic run_and_dump(input logic inject);
		rx_count = 0;
		fork
			send_byte(CMD_RUN);
			receive_dump();
			if (inject)
				inject_load();
		join
	endtask

	////////////////////////////////////////
	// instruction encoding
	////////////////////////////////////////

	function automatic word_t enc_i(input opcode_t op, input int rt, input int rs,
			input int imm);
		word_t w;
		w = '0;
		w[31:26] = op;
		w[25:21] = 5'(rs);
		w[20:16] = 5'(rt);
		w[15:0]  = 16'(imm);
		return w;
	endfunction

	function automatic word_t enc_r(input funct_t fn, input int rd, input int rs,
			input int rt);
		word_t w;
		w = '0;
		w[31:26] = OP_RTYPE;
		w[25:21] = 5'(rs);
		w[20:16] = 5'(rt);
		w[15:11] = 5'(rd);
		w[5:0]   = fn;
		return w;
	endfunction

	function automatic word_t enc_halt();
		word_t w;
		w = '0;
		w[31:26] = OP_HALT;
		return w;
	endfunction

	// random alu or addi, destination at or above dest_lo
	function automatic word_t rand_alu(input int dest_lo);
		int kind;
		int rd;
		int rs;
		int rt;
		int imm;
		word_t w;
		kind = int'($urandom_range(4, 0));
		rd   = int'($urandom_range(7, dest_lo));
		rs   = int'($urandom_range(7, 0));
		rt   = int'($urandom_range(7, 0));
		imm  = int'($urandom_range(65535, 0));
		case (kind)
			0: w = enc_i(OP_ADDI, rd, rs, imm);
			1: w = enc_r(FN_ADD, rd, rs, rt);
			2: w = enc_r(FN_SUB, rd, rs, rt);
			3: w = enc_r(FN_AND, rd, rs, rt);
			default: w = enc_r(FN_OR, rd, rs, rt);
		endcase
		return w;
	endfunction

	////////////////////////////////////////
	// isa reference model
	////////////////////////////////////////

	task automatic model_run();
		imem_addr_t pc;
		word_t      ins;
		word_t      a;
		word_t      b;
		int         simm;
		int         rs;
		int         rt;
		int         rd;
		int         steps;
		logic       stopped;
		pc = '0;
		model_cycles = '0;
		steps = 0;
		stopped = 1'b0;
		while (!stopped && steps < 2000) begin
			ins  = model_imem[pc];
			// register numbers use only their low three bits
			rs   = int'(ins[25:21]) % 8;
			rt   = int'(ins[20:16]) % 8;
			rd   = int'(ins[15:11]) % 8;
			simm = $signed(ins[15:0]);
			a    = model_regs[rs];
			b    = model_regs[rt];
			steps++;
			model_cycles++;
			case (ins[31:26])
				OP_RTYPE: begin
					case (ins[5:0])
						FN_ADD: model_regs[rd] = a + b;
						FN_SUB: model_regs[rd] = a - b;
						FN_AND: model_regs[rd] = a & b;
						FN_OR:  model_regs[rd] = a | b;
						default: ;
					endcase
					pc = pc + 5'd1;
				end
				OP_ADDI: begin
					model_regs[rt] = a + word_t'(simm);
					pc = pc + 5'd1;
				end
				OP_BEQ: begin
					if (a == b)
						pc = pc + 5'd1 + 5'(simm);
					else
						pc = pc + 5'd1;
				end
				// halt stays on its own address
				OP_HALT: stopped = 1'b1;
				default: pc = pc + 5'd1;
			endcase
			// r0 is hardwired
			model_regs[0] = '0;
		end
		if (!stopped)
			report_error("reference model never reached HALT");
		model_pc = pc;
	endtask

	task automatic check_dump();
		word_t exp;
		int    w;
		for (w = 0; w < DUMP_WORDS; w++) begin
			if (w < 8)
				exp = model_regs[w];
			else if (w == 8)
				exp = word_t'(model_pc);
			else
				exp = model_cycles;
			if (dump_words[w] !== exp)
				report_error($sformatf("dump word %0d is %h, expected %h",
					w, dump_words[w], exp));
		end
	endtask

	////////////////////////////////////////
	// test sequence
	////////////////////////////////////////

	initial begin : main
		int i;
		int cnt;
		void'($urandom(32'hcb1b_2373));
		rst_n = 1'b0;
		rx_line = 1'b1;
		test_num = 1;
		test_errors = 0;
		tests_passed = 0;
		tests_failed = 0;
		assert_seen = 0;
		rx_count = 0;
		for (i = 0; i < 8; i++)
			model_regs[i] = '0;
		for (i = 0; i < 32; i++)
			model_imem[i] = '0;
		repeat (4) @(negedge clk);
		rst_n = 1'b1;

		// line must idle high, no frame out of reset
		for (i = 0; i < 100; i++) begin
			@(negedge clk);
			if (tx_line !== 1'b1)
				report_error("tx_line low after reset");
		end
		finish_test("reset state");

		// straight-line program
		for (i = 0; i < 12; i++)
			prog[i] = rand_alu(0);
		prog[12] = enc_halt();
		load_program(13);
		run_and_dump(1'b0);
		model_run();
		check_dump();
		if (dump_words[8] !== 32'd12)
			report_error($sformatf("halt pc is %0d, expected 12", dump_words[8]));
		if (dump_words[9] !== 32'd13)
			report_error($sformatf("cycle count is %0d, expected 13", dump_words[9]));
		finish_test("straight-line program");

		// writes to r0 and negative immediates
		prog[0] = enc_i(OP_ADDI, 0, 0, 77);
		prog[1] = enc_i(OP_ADDI, 1, 0, -3);
		prog[2] = enc_i(OP_ADDI, 2, 1, -100);
		prog[3] = enc_r(FN_ADD, 0, 1, 2);
		prog[4] = enc_i(OP_ADDI, 3, 2, -int'($urandom_range(32768, 1)));
		prog[5] = enc_r(FN_SUB, 4, 0, 3);
		prog[6] = enc_i(OP_ADDI, 5, 0, -32768);
		prog[7] = enc_halt();
		load_program(8);
		run_and_dump(1'b0);
		model_run();
		check_dump();
		if (dump_words[0] !== 32'd0)
			report_error($sformatf("r0 reads %h, expected zero", dump_words[0]));
		finish_test("r0 and sign extension");

		// counted backward loop plus forward branches
		cnt = int'($urandom_range(5, 2));
		prog[0]  = enc_i(OP_ADDI, 1, 0, cnt);
		prog[1]  = enc_i(OP_ADDI, 2, 0, 0);
		prog[2]  = enc_i(OP_ADDI, 2, 2, 1);
		prog[3]  = rand_alu(3);
		// exit when r2 reaches r1, else back to 2
		prog[4]  = enc_i(OP_BEQ, 1, 2, 1);
		prog[5]  = enc_i(OP_BEQ, 0, 0, -4);
		prog[6]  = enc_i(OP_BEQ, 3, 3, 1);
		prog[7]  = enc_i(OP_ADDI, 4, 0, 1234);
		prog[8]  = rand_alu(3);
		prog[9]  = enc_i(OP_BEQ, 5, 4, 1);
		prog[10] = rand_alu(3);
		prog[11] = enc_halt();
		load_program(12);
		run_and_dump(1'b0);
		model_run();
		check_dump();
		finish_test("branches");

		// second run starts from the registers left behind
		for (i = 0; i < 6; i++)
			prog[i] = rand_alu(1);
		prog[6] = enc_halt();
		load_program(7);
		run_and_dump(1'b0);
		model_run();
		check_dump();
		finish_test("state across runs");

		// load byte during the dump is dropped
		for (i = 0; i < 8; i++)
			prog[i] = rand_alu(1);
		prog[8] = enc_halt();
		load_program(9);
		run_and_dump(1'b1);
		model_run();
		check_dump();
		run_and_dump(1'b0);
		model_run();
		check_dump();
		finish_test("ignored commands");

		$display("%0d tests passed, %0d tests failed", tests_passed, tests_failed);
		if (tests_failed == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

// File: files.f
common/mips_dbg_pkg.sv
common/uart_if.sv
common/core_dbg_if.sv
uart/uart_rx.sv
uart/uart_tx.sv
mips/mips_core.sv
debug/debug_unit.sv
verilog/mips_dbg_top.sv
bench/tb_mips_dbg_asserts.sv
bench/tb_mips_dbg.sv

// File: Makefile
VERILATOR ?= verilator
TOP       := tb_mips_dbg
FILELIST  := files.f
VFLAGS    := --binary --timing --assert -Wno-fatal --top-module $(TOP)
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
